//--- sim/ex_cases.txt
# mode stall instr rd data, instr and data in hex, stall (cycles before) and rd in decimal
# mode 0 as listed, 1 random extra stall, 2 idle cycle then stall, 3 isolated latency check
3 0 123450b7  1 12345000   lui x1, 0x12345
0 0 67800113  2 00000678   addi x2, x0, 0x678
0 0 002081b3  3 12345678   add x3, x1, x2
0 0 40218233  4 12345000   sub x4, x3, x2
0 0 003242b3  5 00000678   xor x5, x4, x3 (ex and wb forward)
0 0 0012e333  6 12345678   or x6, x5, x1
0 0 002373b3  7 00000678   and x7, x6, x2
0 0 fff00413  8 ffffffff   addi x8, x0, -1
0 0 007424b3  9 00000001   slt x9, x8, x7
0 0 0083a533 10 00000000   slt x10, x7, x8
0 0 00042593 11 00000001   slti x11, x8, 0
0 0 00400613 12 00000004   addi x12, x0, 4
0 0 00c316b3 13 23456780   sll x13, x6, x12
0 0 00c45733 14 0fffffff   srl x14, x8, x12
0 0 008497b3 15 80000000   sll x15, x9, x8 (shift amount 31)
0 0 0f037813 16 00000070   andi x16, x6, 0x0f0
0 0 f0086893 17 ffffff70   ori x17, x16, -256
0 0 fff8c913 18 0000008f   xori x18, x17, -1
0 1 011909b3 19 ffffffff   add x19, x18, x17 (xori parked by the stall)
0 3 40198a33 20 edcbafff   sub x20, x19, x1 (add parked over three cycles)
2 2 abcdeab7 21 abcde000   lui x21, 0xabcde (stall with decode empty)
0 0 00208033  0 00000000   add x0, x1, x2 (write dropped)
0 0 01500b33 22 abcde000   add x22, x0, x21
0 0 00000b0b  0 00000000   illegal opcode, rd field x22
0 2 0010bb33  0 00000000   sltu, unsupported (stall catches the illegal word)
0 0 000b0bb3 23 abcde000   add x23, x22, x0
1 0 12300c13 24 00000123   addi x24, x0, 0x123
1 0 80000c93 25 fffff800   addi x25, x0, -2048
1 1 019c0d33 26 fffff923   add x26, x24, x25
0 2 018cadb3 27 00000001   slt x27, x25, x24

//--- sources.f
common/core_pkg.sv
verilog/decoder.sv
verilog/reg_file.sv
verilog/pipeline_ctrl.sv
verilog/id_ex_reg.sv
verilog/execute_stage.sv
verilog/ex_pipe_top.sv
sim/tb_ex_pipe.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ex_pipe -f sources.f -o sim_ex_pipe

out=$(./obj_dir/sim_ex_pipe 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Testbench passed$"; then
	exit 0
fi
exit 1

//--- sim/tb_ex_pipe.sv
module tb_ex_pipe;

	localparam int DRAIN_LIMIT = 100; // cycles to wait for outstanding writebacks
	localparam int LATENCY_LIMIT = 20;
	localparam int WB_LATENCY = 3; // edges from presenting an instruction to wb.en

	logic clk;
	logic rst;
	logic instr_valid;
	core_pkg::word_t instr;
	logic stall;
	core_pkg::wb_t wb;

	core_pkg::wb_t expected_q[$]; // writebacks still owed, oldest first
	int seed = 6296;
	int case_count;

	ex_pipe_top i_dut (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.stall(stall),
		.wb(wb)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_rd(input core_pkg::reg_addr_t got, input core_pkg::reg_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH wb.rd got %h expected %h", got, exp));
	endtask

	task automatic check_data(input core_pkg::word_t got, input core_pkg::word_t exp);
		if (got !== exp)
			abort_run($sformatf("MISMATCH wb.data got %h expected %h", got, exp));
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("MISMATCH wb latency got %h expected %h", got, exp));
	endtask

	// stall high with nothing presented
	task automatic hold_stall(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			stall <= 1'b1;
		end
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		instr_valid <= 1'b0;
		stall <= 1'b0;
	endtask

	task automatic present(input core_pkg::word_t word, input int rd_num,
		input core_pkg::word_t data);
		core_pkg::wb_t exp_wb;
		@(posedge clk);
		stall <= 1'b0;
		instr_valid <= 1'b1;
		instr <= word;
		if (rd_num != 0) begin // rd zero owes no writeback
			exp_wb.en = 1'b1;
			exp_wb.rd = rd_num[4:0];
			exp_wb.data = data;
			expected_q.push_back(exp_wb);
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			stall <= 1'b0;
			cycles++;
			if (cycles > DRAIN_LIMIT)
				abort_run($sformatf("timeout, %0d writebacks never arrived",
					expected_q.size()));
		end
	endtask

	// one instruction into an empty pipe, count edges until wb.en shows up
	task automatic measure_latency(input core_pkg::word_t word, input int rd_num,
		input core_pkg::word_t data);
		int edges;
		logic seen;
		wait_drain();
		repeat (3) idle_cycle(); // non-writers leave the pipe too
		present(word, rd_num, data);
		edges = 0;
		seen = 1'b0;
		while (!seen) begin
			@(posedge clk);
			instr_valid <= 1'b0;
			edges++;
			@(negedge clk);
			seen = (wb.en === 1'b1);
			if (!seen && edges > LATENCY_LIMIT)
				abort_run("isolated instruction never reached writeback");
		end
		check_latency(edges, WB_LATENCY);
	endtask

	task automatic run_case(input int mode, input int stall_n, input core_pkg::word_t word,
		input int rd_num, input core_pkg::word_t data);
		int extra;
		case (mode)
			0: begin
				hold_stall(stall_n);
				present(word, rd_num, data);
			end
			1: begin
				extra = $unsigned($random(seed)) % 3; // 0 to 2 extra stall cycles
				hold_stall(stall_n + extra);
				present(word, rd_num, data);
			end
			2: begin
				idle_cycle(); // decode is empty when the stall starts
				hold_stall(stall_n);
				present(word, rd_num, data);
			end
			3: measure_latency(word, rd_num, data);
			default: abort_run($sformatf("unknown mode %0d in cases file", mode));
		endcase
	endtask

	// writebacks checked in order against the queue
	always @(negedge clk) begin
		core_pkg::wb_t exp_wb;
		if (!rst && wb.en === 1'b1) begin
			if (expected_q.size() == 0) begin
				abort_run($sformatf("writeback to x%0d with no instruction pending",
					wb.rd));
			end else begin
				exp_wb = expected_q.pop_front();
				check_rd(wb.rd, exp_wb.rd);
				check_data(wb.data, exp_wb.data);
			end
		end
	end

	initial begin
		int fd;
		int code;
		string line;
		int mode;
		int stall_n;
		core_pkg::word_t word;
		int rd_num;
		core_pkg::word_t data;

		rst <= 1'b1;
		instr_valid <= 1'b0;
		instr <= '0;
		stall <= 1'b0;
		case_count = 0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		fd = $fopen("sim/ex_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open sim/ex_cases.txt");
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			code = $sscanf(line, "%d %d %h %d %h", mode, stall_n, word, rd_num, data);
			if (code == 5) begin // comment and blank lines fall through
				case_count++;
				run_case(mode, stall_n, word, rd_num, data);
			end
		end
		$fclose(fd);

		wait_drain();
		repeat (8) idle_cycle(); // a stray wb.en here finds the queue empty
		if (expected_q.size() == 0 && case_count > 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			abort_run($sformatf("run ended with %0d cases read and %0d writebacks owed",
				case_count, expected_q.size()));
		end
	end

endmodule

//--- verilog/ex_pipe_top.sv
module ex_pipe_top (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input core_pkg::word_t instr,
	input logic stall,
	output core_pkg::wb_t wb
);
	logic accept;
	logic dec_valid;
	core_pkg::word_t dec_instr;

	core_pkg::alu_op_e dec_alu_op;
	logic dec_regwr;
	core_pkg::reg_addr_t dec_rd;
	core_pkg::reg_addr_t dec_rs1;
	core_pkg::reg_addr_t dec_rs2;
	core_pkg::word_t dec_imm;
	logic dec_use_imm;
	logic dec_illegal;

	core_pkg::word_t rf_rd1;
	core_pkg::word_t rf_rd2;
	core_pkg::word_t alu_result;
	core_pkg::fwd_sel_e fwd1;
	core_pkg::fwd_sel_e fwd2;
	core_pkg::ex_cmd_e cmd;
	core_pkg::id_ex_t id_bundle;
	core_pkg::id_ex_t ex_bundle;

	function automatic core_pkg::word_t fwd_mux(input core_pkg::fwd_sel_e sel,
		input core_pkg::word_t rf_val, input core_pkg::word_t ex_val,
		input core_pkg::word_t wb_val);
		core_pkg::word_t val;
		case (sel)
			core_pkg::FWD_EX: val = ex_val;
			core_pkg::FWD_WB: val = wb_val;
			default: val = rf_val;
		endcase
		return val;
	endfunction

	assign accept = instr_valid && !stall;

	// decode register, empties whenever nothing is taken
	always_ff @(posedge clk) begin
		if (accept)
			dec_instr <= instr;
		if (rst)
			dec_valid <= 1'b0;
		else
			dec_valid <= accept;
	end

	decoder u_decoder (
		.instr(dec_instr),
		.alu_op(dec_alu_op),
		.regwr(dec_regwr),
		.rd(dec_rd),
		.rs1(dec_rs1),
		.rs2(dec_rs2),
		.imm(dec_imm),
		.use_imm(dec_use_imm),
		.illegal(dec_illegal)
	);

	reg_file u_reg_file (
		.clk(clk),
		.rs1(dec_rs1),
		.rs2(dec_rs2),
		.rd1(rf_rd1),
		.rd2(rf_rd2),
		.wb(wb)
	);

	always_comb begin
		id_bundle.valid = dec_valid && !dec_illegal; // illegal words go down as bubbles
		id_bundle.alu_op = dec_alu_op;
		id_bundle.regwr = dec_regwr;
		id_bundle.rd = dec_rd;
		id_bundle.op1 = fwd_mux(fwd1, rf_rd1, alu_result, wb.data);
		if (dec_use_imm)
			id_bundle.op2 = dec_imm;
		else
			id_bundle.op2 = fwd_mux(fwd2, rf_rd2, alu_result, wb.data);
	end

	pipeline_ctrl u_pipeline_ctrl (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.id_valid(id_bundle.valid),
		.id_rs1(dec_rs1),
		.id_rs2(dec_rs2),
		.ex_bundle(ex_bundle),
		.wb(wb),
		.cmd(cmd),
		.fwd1(fwd1),
		.fwd2(fwd2)
	);

	id_ex_reg u_id_ex_reg (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.id_bundle(id_bundle),
		.ex_bundle(ex_bundle)
	);

	execute_stage u_execute_stage (
		.clk(clk),
		.rst(rst),
		.ex_bundle(ex_bundle),
		.alu_result(alu_result),
		.wb(wb)
	);

endmodule

//--- verilog/execute_stage.sv
module execute_stage (
	input logic clk,
	input logic rst,
	input core_pkg::id_ex_t ex_bundle,
	output core_pkg::word_t alu_result,
	output core_pkg::wb_t wb
);
	core_pkg::word_t op1;
	core_pkg::word_t op2;

	assign op1 = ex_bundle.op1;
	assign op2 = ex_bundle.op2;

	always_comb begin
		case (ex_bundle.alu_op)
			core_pkg::ALU_ADD: alu_result = op1 + op2;
			core_pkg::ALU_SUB: alu_result = op1 - op2;
			core_pkg::ALU_AND: alu_result = op1 & op2;
			core_pkg::ALU_OR: alu_result = op1 | op2;
			core_pkg::ALU_XOR: alu_result = op1 ^ op2;
			core_pkg::ALU_SLT: alu_result = {31'd0, $signed(op1) < $signed(op2)};
			core_pkg::ALU_SLL: alu_result = op1 << op2[4:0];
			core_pkg::ALU_SRL: alu_result = op1 >> op2[4:0];
			core_pkg::ALU_PASS2: alu_result = op2; // lui
			default: alu_result = '0;
		endcase
	end

	// EX/WB register, also the WB forwarding source
	always_ff @(posedge clk) begin
		wb.rd <= ex_bundle.rd;
		wb.data <= alu_result;
		if (rst)
			wb.en <= 1'b0;
		else
			wb.en <= ex_bundle.valid && ex_bundle.regwr;
	end

endmodule

//--- verilog/id_ex_reg.sv
module id_ex_reg (
	input logic clk,
	input logic rst,
	input core_pkg::ex_cmd_e cmd,
	input core_pkg::id_ex_t id_bundle,
	output core_pkg::id_ex_t ex_bundle
);
	core_pkg::id_ex_t parked; // one-entry stall buffer
	logic full;

	always_ff @(posedge clk) begin
		if (cmd == core_pkg::CMD_CAPTURE)
			parked <= id_bundle;
	end

	always_ff @(posedge clk) begin
		if (rst)
			full <= 1'b0;
		else if (cmd == core_pkg::CMD_CAPTURE)
			full <= 1'b1;
		else if (cmd == core_pkg::CMD_RELEASE)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_bundle.valid <= 1'b0;
			ex_bundle.regwr <= 1'b0;
		end else begin
			case (cmd)
				core_pkg::CMD_PASS: ex_bundle <= id_bundle;
				core_pkg::CMD_RELEASE: ex_bundle <= parked;
				default: begin
					// capture and bubble both send a bubble, payload is don't care
					ex_bundle.valid <= 1'b0;
					ex_bundle.regwr <= 1'b0;
				end
			endcase
		end
	end

	// controller's captured flag has to track the buffer
	capture_when_empty: assert property (@(posedge clk) disable iff (rst)
		cmd == core_pkg::CMD_CAPTURE |-> !full);

	release_when_full: assert property (@(posedge clk) disable iff (rst)
		cmd == core_pkg::CMD_RELEASE |-> full);

endmodule

//--- verilog/pipeline_ctrl.sv
module pipeline_ctrl (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic id_valid,
	input core_pkg::reg_addr_t id_rs1,
	input core_pkg::reg_addr_t id_rs2,
	input core_pkg::id_ex_t ex_bundle,
	input core_pkg::wb_t wb,
	output core_pkg::ex_cmd_e cmd,
	output core_pkg::fwd_sel_e fwd1,
	output core_pkg::fwd_sel_e fwd2
);
	// replay is run mode with the parked instruction now in EX
	typedef enum logic [1:0] {
		ST_RUN,
		ST_HELD,
		ST_REPLAY
	} state_e;

	state_e state;
	state_e state_next;
	logic captured; // onset parked an instruction
	logic captured_next;
	logic ex_writes;

	assign ex_writes = ex_bundle.valid && ex_bundle.regwr && (ex_bundle.rd != 5'd0);

	// youngest producer first, EX before WB
	function automatic core_pkg::fwd_sel_e pick_src(input core_pkg::reg_addr_t rs);
		core_pkg::fwd_sel_e sel;
		if (ex_writes && ex_bundle.rd == rs)
			sel = core_pkg::FWD_EX;
		else if (wb.en && wb.rd == rs) // wb.en implies rd nonzero
			sel = core_pkg::FWD_WB;
		else
			sel = core_pkg::FWD_RF;
		return sel;
	endfunction

	always_comb begin
		fwd1 = pick_src(id_rs1);
		fwd2 = pick_src(id_rs2);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_RUN;
			captured <= 1'b0;
		end else begin
			state <= state_next;
			captured <= captured_next;
		end
	end

	always_comb begin
		cmd = core_pkg::CMD_PASS;
		state_next = state;
		captured_next = captured;
		case (state)
			ST_RUN, ST_REPLAY: begin
				state_next = ST_RUN;
				if (stall) begin
					if (id_valid)
						cmd = core_pkg::CMD_CAPTURE;
					else
						cmd = core_pkg::CMD_BUBBLE;
					captured_next = id_valid;
					state_next = ST_HELD;
				end
			end
			ST_HELD: begin
				if (stall) begin
					cmd = core_pkg::CMD_BUBBLE;
				end else if (captured) begin
					cmd = core_pkg::CMD_RELEASE;
					captured_next = 1'b0;
					state_next = ST_REPLAY;
				end else begin
					state_next = ST_RUN; // nothing parked, decode is empty
				end
			end
			default: state_next = ST_RUN;
		endcase
	end

	// EX has carried only bubbles since the onset
	release_after_stall: assert property (@(posedge clk) disable iff (rst)
		cmd == core_pkg::CMD_RELEASE |-> state == ST_HELD && !ex_bundle.valid);

	// the replayed bundle must actually reach execute
	replay_in_ex: assert property (@(posedge clk) disable iff (rst)
		state == ST_REPLAY |-> ex_bundle.valid);

endmodule

//--- verilog/reg_file.sv
module reg_file (
	input logic clk,
	input core_pkg::reg_addr_t rs1,
	input core_pkg::reg_addr_t rs2,
	output core_pkg::word_t rd1,
	output core_pkg::word_t rd2,
	input core_pkg::wb_t wb
);
	core_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (wb.en && wb.rd != 5'd0)
			regs[wb.rd] <= wb.data;
	end

	// x0 is hard zero whatever the array holds
	assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

	// decoder drops regwr for x0 so execute never retires a write to it
	wb_rd_nonzero: assert property (@(posedge clk) wb.en |-> wb.rd != 5'd0);

endmodule

//--- verilog/decoder.sv
module decoder (
	input core_pkg::word_t instr,
	output core_pkg::alu_op_e alu_op,
	output logic regwr,
	output core_pkg::reg_addr_t rd,
	output core_pkg::reg_addr_t rs1,
	output core_pkg::reg_addr_t rs2,
	output core_pkg::word_t imm,
	output logic use_imm,
	output logic illegal
);
	logic [2:0] func3;
	logic [6:0] func7;
	logic f7_zero;
	logic f7_alt; // sub encoding

	assign func3 = instr[14:12];
	assign func7 = instr[31:25];
	assign f7_zero = (func7 == 7'b0000000);
	assign f7_alt = (func7 == 7'b0100000);

	assign rd = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	// x0 targets and bad words pass on as non-writers
	assign regwr = !illegal && (rd != 5'd0);

	always_comb begin
		alu_op = core_pkg::ALU_ADD;
		imm = '0;
		use_imm = 1'b0;
		illegal = 1'b0;
		case (instr[6:0])
			core_pkg::OP_REG: begin
				illegal = !f7_zero;
				case (func3)
					3'b000: begin
						alu_op = f7_alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
						illegal = !(f7_zero || f7_alt);
					end
					3'b001: alu_op = core_pkg::ALU_SLL;
					3'b010: alu_op = core_pkg::ALU_SLT;
					3'b100: alu_op = core_pkg::ALU_XOR;
					3'b101: alu_op = core_pkg::ALU_SRL;
					3'b110: alu_op = core_pkg::ALU_OR;
					3'b111: alu_op = core_pkg::ALU_AND;
					default: illegal = 1'b1; // sltu
				endcase
			end
			core_pkg::OP_IMM: begin
				imm = {{20{instr[31]}}, instr[31:20]};
				use_imm = 1'b1;
				case (func3)
					3'b000: alu_op = core_pkg::ALU_ADD;
					3'b010: alu_op = core_pkg::ALU_SLT;
					3'b100: alu_op = core_pkg::ALU_XOR;
					3'b110: alu_op = core_pkg::ALU_OR;
					3'b111: alu_op = core_pkg::ALU_AND;
					default: illegal = 1'b1; // no immediate shifts here
				endcase
			end
			core_pkg::OP_LUI: begin
				imm = {instr[31:12], 12'd0};
				use_imm = 1'b1;
				alu_op = core_pkg::ALU_PASS2;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

//--- common/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// major opcode field, RV32I encodings
	typedef enum logic [6:0] {
		OP_REG = 7'b0110011,
		OP_IMM = 7'b0010011,
		OP_LUI = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS2 // lui, op2 straight through
	} alu_op_e;

	// operand source into decode
	typedef enum logic [1:0] {
		FWD_RF,
		FWD_EX,
		FWD_WB
	} fwd_sel_e;

	typedef enum logic [1:0] {
		CMD_PASS,
		CMD_CAPTURE,
		CMD_BUBBLE,
		CMD_RELEASE
	} ex_cmd_e;

	// decode to execute, operands already resolved
	typedef struct packed {
		logic valid;
		alu_op_e alu_op;
		logic regwr;
		reg_addr_t rd;
		word_t op1;
		word_t op2;
	} id_ex_t;

	typedef struct packed {
		logic en;
		reg_addr_t rd;
		word_t data;
	} wb_t;

endpackage
